// File: logic/lsab_pkg.sv
package lsab_pkg;

  localparam int NUM_QUEUES      = 4;
  localparam int QUEUE_DEPTH     = 64;  // ram slots per queue
  localparam int QUEUE_CAPACITY  = QUEUE_DEPTH - 1;  // one slot always free
  localparam int NEAR_FULL_LEVEL = 55;
  localparam int WORD_WIDTH      = 32;

  typedef logic [WORD_WIDTH-1:0] word_t;

  typedef logic [$clog2(NUM_QUEUES)-1:0] qsel_t;

  typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;

  // 0 .. QUEUE_CAPACITY
  typedef logic [$clog2(QUEUE_CAPACITY + 1)-1:0] len_t;

  // queue index on top, slot index below
  typedef logic [$clog2(NUM_QUEUES * QUEUE_DEPTH)-1:0] ram_addr_t;

endpackage

// File: logic/lsab_ram_if.sv
interface lsab_ram_if;

  logic                  we;
  lsab_pkg::ram_addr_t   waddr;
  lsab_pkg::word_t       wdata;

  logic                  re;
  lsab_pkg::ram_addr_t   raddr;
  lsab_pkg::word_t       rdata;  // held until next read

  modport writer (
    output we,
    output waddr,
    output wdata
  );

  modport reader (
    output re,
    output raddr,
    input  rdata
  );

  modport mem (
    input  we,
    input  waddr,
    input  wdata,
    input  re,
    input  raddr,
    output rdata
  );

endinterface

// File: logic/lsab_count_if.sv
interface lsab_count_if;

  logic                                wr_accept;  // single cycle, already gated
  lsab_pkg::qsel_t                     wr_queue;
  logic                                rd_accept;
  lsab_pkg::qsel_t                     rd_queue;
  logic [lsab_pkg::NUM_QUEUES-1:0]     full;
  logic [lsab_pkg::NUM_QUEUES-1:0]     empty;

  modport producer (
    output wr_accept,
    output wr_queue,
    input  full
  );

  modport consumer (
    output rd_accept,
    output rd_queue,
    input  empty
  );

  modport counter (
    input  wr_accept,
    input  wr_queue,
    input  rd_accept,
    input  rd_queue,
    output full,
    output empty
  );

endinterface

// File: logic/queue_ram.sv
module queue_ram (
  input logic      CLK,
  lsab_ram_if.mem  ram
);

  localparam int NUM_WORDS = lsab_pkg::NUM_QUEUES * lsab_pkg::QUEUE_DEPTH;

  lsab_pkg::word_t mem [NUM_WORDS];

  // write side
  always_ff @(posedge CLK) begin
    if (ram.we) begin
      mem[ram.waddr] <= ram.wdata;
    end
  end

  // read side, word registered on re
  always_ff @(posedge CLK) begin
    if (ram.re) begin
      ram.rdata <= mem[ram.raddr];
    end
  end

endmodule

// File: logic/queue_occupancy.sv
module queue_occupancy (
  input  logic                            CLK,
  input  logic                            RST,
  lsab_count_if.counter                   cnt,
  output logic [lsab_pkg::NUM_QUEUES-1:0] near_full
);

  lsab_pkg::len_t [lsab_pkg::NUM_QUEUES-1:0] len;
  lsab_pkg::len_t [lsab_pkg::NUM_QUEUES-1:0] len_next;
  logic [lsab_pkg::NUM_QUEUES-1:0]           wr_hit;
  logic [lsab_pkg::NUM_QUEUES-1:0]           rd_hit;

  always_comb begin
    for (int q = 0; q < lsab_pkg::NUM_QUEUES; q++) begin
      wr_hit[q] = cnt.wr_accept && (cnt.wr_queue == lsab_pkg::qsel_t'(q));
      rd_hit[q] = cnt.rd_accept && (cnt.rd_queue == lsab_pkg::qsel_t'(q));
      case ({wr_hit[q], rd_hit[q]})
        2'b10:   len_next[q] = len[q] + 1'b1;
        2'b01:   len_next[q] = len[q] - 1'b1;
        default: len_next[q] = len[q];  // idle, or both at once
      endcase
    end
  end

  // flags come from the next length so they line up with len
  always_ff @(posedge CLK) begin
    if (RST) begin
      len       <= '0;
      cnt.empty <= '1;
      cnt.full  <= '0;
      near_full <= '0;
    end else begin
      len <= len_next;
      for (int q = 0; q < lsab_pkg::NUM_QUEUES; q++) begin
        cnt.empty[q] <= (len_next[q] == '0);
        cnt.full[q]  <= (len_next[q] == lsab_pkg::len_t'(lsab_pkg::QUEUE_CAPACITY));
        near_full[q] <= (len_next[q] >= lsab_pkg::len_t'(lsab_pkg::NEAR_FULL_LEVEL));
      end
    end
  end

endmodule

// File: logic/write_port.sv
module write_port (
  input  logic             CLK,
  input  logic             RST,
  input  logic             write,
  input  lsab_pkg::qsel_t  write_queue,
  input  lsab_pkg::word_t  data_in,
  lsab_ram_if.writer       ram,
  lsab_count_if.producer   cnt
);

  lsab_pkg::ptr_t [lsab_pkg::NUM_QUEUES-1:0] wptr;
  logic                                      accept;

  assign accept = write && !cnt.full[write_queue];  // dropped when full

  assign ram.we    = accept;
  assign ram.waddr = {write_queue, wptr[write_queue]};
  assign ram.wdata = data_in;

  assign cnt.wr_accept = accept;
  assign cnt.wr_queue  = write_queue;

  // pointer wraps inside the queue's slice of the ram
  always_ff @(posedge CLK) begin
    if (RST) begin
      wptr <= '0;
    end else if (accept) begin
      wptr[write_queue] <= wptr[write_queue] + 1'b1;
    end
  end

endmodule

// File: logic/read_port.sv
module read_port (
  input  logic                                       CLK,
  input  logic                                       RST,
  input  logic [lsab_pkg::NUM_QUEUES-1:0]            read,
  input  lsab_pkg::qsel_t                            read_queue,
  lsab_ram_if.reader                                 ram,
  lsab_count_if.consumer                             cnt,
  output lsab_pkg::word_t [lsab_pkg::NUM_QUEUES-1:0] data_out
);

  lsab_pkg::ptr_t [lsab_pkg::NUM_QUEUES-1:0] rptr;
  logic                                      accept;
  logic                                      rd_valid;    // rdata is fresh
  lsab_pkg::qsel_t                           rd_queue_d;  // where rdata goes

  assign accept = read[read_queue] && !cnt.empty[read_queue];

  assign ram.re    = accept;
  assign ram.raddr = {read_queue, rptr[read_queue]};

  assign cnt.rd_accept = accept;
  assign cnt.rd_queue  = read_queue;

  always_ff @(posedge CLK) begin
    if (RST) begin
      rptr <= '0;
    end else if (accept) begin
      rptr[read_queue] <= rptr[read_queue] + 1'b1;
    end
  end

  // second stage of the read path, one read may follow another directly
  always_ff @(posedge CLK) begin
    if (RST) begin
      rd_valid   <= 1'b0;
      rd_queue_d <= '0;
    end else begin
      rd_valid   <= accept;
      rd_queue_d <= read_queue;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      data_out <= '0;
    end else if (rd_valid) begin
      data_out[rd_queue_d] <= ram.rdata;
    end
  end

endmodule

// File: logic/lsab_top.sv
module lsab_top (
  input  logic                                       CLK,
  input  logic                                       RST,
  input  logic                                       write,
  input  lsab_pkg::qsel_t                            write_queue,
  input  lsab_pkg::word_t                            data_in,
  input  logic [lsab_pkg::NUM_QUEUES-1:0]            read,
  input  lsab_pkg::qsel_t                            read_queue,
  output lsab_pkg::word_t [lsab_pkg::NUM_QUEUES-1:0] data_out,
  output logic [lsab_pkg::NUM_QUEUES-1:0]            near_full
);

  lsab_ram_if   ram_bus ();
  lsab_count_if cnt_bus ();

  write_port u_write_port (
    .CLK         (CLK),
    .RST         (RST),
    .write       (write),
    .write_queue (write_queue),
    .data_in     (data_in),
    .ram         (ram_bus.writer),
    .cnt         (cnt_bus.producer)
  );

  read_port u_read_port (
    .CLK        (CLK),
    .RST        (RST),
    .read       (read),
    .read_queue (read_queue),
    .ram        (ram_bus.reader),
    .cnt        (cnt_bus.consumer),
    .data_out   (data_out)
  );

  queue_occupancy u_occupancy (
    .CLK       (CLK),
    .RST       (RST),
    .cnt       (cnt_bus.counter),
    .near_full (near_full)
  );

  // shared by all four queues
  queue_ram u_ram (
    .CLK (CLK),
    .ram (ram_bus.mem)
  );

endmodule

// File: verif/lsab_tb.sv
module lsab_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 3000;  // about twice the length of all tests

  logic                                       CLK = 1'b0;
  logic                                       RST;
  logic                                       write;
  lsab_pkg::qsel_t                            write_queue;
  lsab_pkg::word_t                            data_in;
  logic [lsab_pkg::NUM_QUEUES-1:0]            read;
  lsab_pkg::qsel_t                            read_queue;
  lsab_pkg::word_t [lsab_pkg::NUM_QUEUES-1:0] data_out;
  logic [lsab_pkg::NUM_QUEUES-1:0]            near_full;

  lsab_pkg::word_t model_q [lsab_pkg::NUM_QUEUES][$];
  lsab_pkg::word_t exp_out [lsab_pkg::NUM_QUEUES];
  logic            pipe1_valid = 1'b0;  // read accepted on the last edge
  lsab_pkg::qsel_t pipe1_queue;
  lsab_pkg::word_t pipe1_word;

  string test_name = "reset";
  int    errors = 0;
  int    checks = 0;
  int    cycle_count = 0;

  lsab_top u_dut (
    .CLK         (CLK),
    .RST         (RST),
    .write       (write),
    .write_queue (write_queue),
    .data_in     (data_in),
    .read        (read),
    .read_queue  (read_queue),
    .data_out    (data_out),
    .near_full   (near_full)
  );

  always #10 CLK = ~CLK;

  function automatic logic near_full_ref(input int len);
    return len >= lsab_pkg::NEAR_FULL_LEVEL;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // one cycle of inputs, taken by the DUT on the next edge
  task automatic apply_cycle(input logic wr, input lsab_pkg::qsel_t wq,
                             input lsab_pkg::word_t wd,
                             input logic [lsab_pkg::NUM_QUEUES-1:0] rd,
                             input lsab_pkg::qsel_t rq);
    @(posedge CLK);
    write       <= wr;
    write_queue <= wq;
    data_in     <= wd;
    read        <= rd;
    read_queue  <= rq;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) apply_cycle(1'b0, '0, '0, '0, '0);
  endtask

  task automatic write_word(input lsab_pkg::qsel_t q, input lsab_pkg::word_t d);
    apply_cycle(1'b1, q, d, '0, '0);
  endtask

  task automatic read_word(input lsab_pkg::qsel_t q);
    logic [lsab_pkg::NUM_QUEUES-1:0] onehot;
    onehot    = '0;
    onehot[q] = 1'b1;
    apply_cycle(1'b0, '0, '0, onehot, q);
  endtask

  // model and comparator see the inputs the DUT takes on this edge
  always @(posedge CLK) begin
    logic wr_ok;
    logic rd_ok;
    if (RST) begin
      for (int q = 0; q < lsab_pkg::NUM_QUEUES; q++) begin
        model_q[q].delete();
        exp_out[q] = '0;
      end
      pipe1_valid = 1'b0;
    end else begin
      for (int q = 0; q < lsab_pkg::NUM_QUEUES; q++) begin
        checks++;
        if (data_out[q] !== exp_out[q]) begin
          errors++;
          $display("** Error [%s] data_out[%0d]: expected %h, actual %h",
                   test_name, q, exp_out[q], data_out[q]);
        end
        if (near_full[q] !== near_full_ref(model_q[q].size())) begin
          errors++;
          $display("** Error [%s] near_full[%0d]: expected %b, actual %b",
                   test_name, q, near_full_ref(model_q[q].size()), near_full[q]);
        end
      end
      if (pipe1_valid) begin
        exp_out[pipe1_queue] = pipe1_word;  // loaded one edge after acceptance
      end
      wr_ok = write && (model_q[write_queue].size() < lsab_pkg::QUEUE_CAPACITY);
      rd_ok = read[read_queue] && (model_q[read_queue].size() > 0);
      pipe1_valid = rd_ok;
      pipe1_queue = read_queue;
      if (rd_ok) begin
        pipe1_word = model_q[read_queue].pop_front();
      end
      if (wr_ok) begin
        model_q[write_queue].push_back(data_in);
      end
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles before the tests finished", cycle_count);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    logic [31:0]     rng;
    logic [31:0]     r1;
    logic [31:0]     r2;
    lsab_pkg::qsel_t rq;
    rng         = 32'hfe95;
    RST         = 1'b1;
    write       = 1'b0;
    write_queue = '0;
    data_in     = '0;
    read        = '0;
    read_queue  = '0;
    repeat (8) @(posedge CLK);
    RST <= 1'b0;

    test_name = "after_reset";
    idle_cycles(2);
    for (int q = 0; q < lsab_pkg::NUM_QUEUES; q++) begin
      read_word(lsab_pkg::qsel_t'(q));  // every queue empty so nothing returns
    end
    idle_cycles(4);

    test_name = "order_queue2";
    for (int i = 0; i < 20; i++) begin
      write_word(2'd2, 32'h2000_0000 | 32'(i));
    end
    for (int i = 0; i < 20; i++) begin
      read_word(2'd2);
    end
    idle_cycles(4);

    test_name = "full_queue0";
    for (int i = 0; i < 70; i++) begin
      write_word(2'd0, 32'h0f00_0000 | 32'(i));  // last 7 refused
    end
    for (int i = 0; i < 64; i++) begin
      read_word(2'd0);
    end
    idle_cycles(4);

    test_name = "near_full_queue1";
    for (int i = 0; i < lsab_pkg::QUEUE_CAPACITY; i++) begin
      write_word(2'd1, 32'h1100_0000 | 32'(i));
    end
    for (int i = 0; i < lsab_pkg::QUEUE_CAPACITY; i++) begin
      read_word(2'd1);
    end
    idle_cycles(4);

    test_name = "random_mix";
    for (int i = 0; i < 800; i++) begin
      rng = xorshift32(rng);
      r1  = rng;
      rng = xorshift32(rng);
      r2  = rng;
      rq  = r1[8] ? r1[3:2] : r1[10:9];  // often the queue being written
      apply_cycle(r1[0] | r1[1], r1[3:2], r2, r1[7:4], rq);
    end
    idle_cycles(4);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: flist.f
logic/lsab_pkg.sv
logic/lsab_ram_if.sv
logic/lsab_count_if.sv
logic/queue_ram.sv
logic/queue_occupancy.sv
logic/write_port.sv
logic/read_port.sv
logic/lsab_top.sv
verif/lsab_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= lsab_tb
FLIST     ?= flist.f

BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
